//--- logic/fcvt_macros.svh
/* Format constants for the 32-bit integer/float conversion unit.
   IEEE-754 single precision only; the widths are not meant to be changed */
`ifndef FCVT_MACROS_SVH
`define FCVT_MACROS_SVH

// Operand and result width
`define FCVT_WORD_BITS 32

// Single-precision field layout
`define FCVT_EXP_BITS 8
`define FCVT_MAN_BITS 23
`define FCVT_EXP_BIAS 127

// Saturation words for float-to-integer
`define FCVT_INT_MAX 32'h7fffffff
`define FCVT_INT_MIN 32'h80000000

// Operation codes seen on the op input
`define FCVT_OP_I2F 1'b0
`define FCVT_OP_F2I 1'b1

`endif

//--- logic/fcvt_pkg.sv
/* Shared vector types and FSM state encodings of the conversion unit */
`include "fcvt_macros.svh"

package fcvt_pkg;

        // Operand and result word
        typedef logic [`FCVT_WORD_BITS-1:0] word_t;

        // Biased exponent field
        typedef logic [`FCVT_EXP_BITS-1:0] exp_t;

        // Mantissa with the hidden bit in the top position
        typedef logic [`FCVT_MAN_BITS:0] man_t;

        typedef logic [0:0] op_t;

        typedef enum logic [2:0] {
                I2F_IDLE,
                I2F_CONVERT,
                I2F_NORMALIZE,
                I2F_ROUND,
                I2F_PACK
        } i2f_state_t;

        typedef enum logic [1:0] {
                F2I_IDLE,
                F2I_DECODE,
                F2I_SHIFT,
                F2I_RESULT
        } f2i_state_t;

        typedef enum logic [1:0] {
                CTRL_IDLE,
                CTRL_RUN,
                CTRL_HOLD,
                CTRL_RELEASE
        } ctrl_state_t;

endpackage

//--- logic/int_to_float.sv
/* Signed integer to single-precision float, round to nearest even, zero gives +0.
   Takes 3 cycles for zero, otherwise 5 plus one per normalize shift (36 at most).
   A start seen while busy is ignored */
`timescale 1ns/10ps
`include "fcvt_macros.svh"

module int_to_float (
        input  logic            clk,
        input  logic            rst,
        input  logic            start,
        input  fcvt_pkg::word_t a,
        output fcvt_pkg::word_t z,
        output logic            done
);
        import fcvt_pkg::*;

        i2f_state_t state;

        word_t      a_q;
        word_t      a_abs;
        exp_t       packed_exp;

        // Working fields, unbiased exponent until packing
        logic       z_s;
        exp_t       z_e;
        man_t       z_m;
        logic [7:0] z_r;

        logic       guard;
        logic       round_bit;
        logic       sticky;

        // -2^31 negates to itself, which reads correctly as an unsigned magnitude
        assign a_abs = a_q[`FCVT_WORD_BITS-1] ? -a_q : a_q;

        assign packed_exp = z_e + exp_t'(`FCVT_EXP_BIAS);

        always_ff @(posedge clk) begin
                if (!rst) begin
                        state <= I2F_IDLE;
                        done  <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                        I2F_IDLE: begin
                                if (start) begin
                                        a_q   <= a;
                                        state <= I2F_CONVERT;
                                end
                        end

                        I2F_CONVERT: begin
                                if (a_q == '0) begin
                                        // Exponent of -bias packs to a zero field
                                        z_s   <= 1'b0;
                                        z_m   <= '0;
                                        z_e   <= exp_t'(-`FCVT_EXP_BIAS);
                                        state <= I2F_PACK;
                                end else begin
                                        z_s   <= a_q[`FCVT_WORD_BITS-1];
                                        z_e   <= exp_t'(`FCVT_WORD_BITS - 1);
                                        z_m   <= a_abs[`FCVT_WORD_BITS-1:8];
                                        z_r   <= a_abs[7:0];
                                        state <= I2F_NORMALIZE;
                                end
                        end

                        I2F_NORMALIZE: begin
                                if (!z_m[`FCVT_MAN_BITS]) begin
                                        z_e <= z_e - 1'b1;
                                        z_m <= {z_m[`FCVT_MAN_BITS-1:0], z_r[7]};
                                        z_r <= {z_r[6:0], 1'b0};
                                end else begin
                                        guard     <= z_r[7];
                                        round_bit <= z_r[6];
                                        sticky    <= (z_r[5:0] != '0);
                                        state     <= I2F_ROUND;
                                end
                        end

                        I2F_ROUND: begin
                                // On a tie the lsb of the mantissa decides
                                if (guard && (round_bit || sticky || z_m[0])) begin
                                        z_m <= z_m + 1'b1;
                                        if (z_m == '1) begin
                                                z_e <= z_e + 1'b1;
                                        end
                                end
                                state <= I2F_PACK;
                        end

                        I2F_PACK: begin
                                z     <= {z_s, packed_exp, z_m[`FCVT_MAN_BITS-1:0]};
                                done  <= 1'b1;
                                state <= I2F_IDLE;
                        end

                        default: begin
                                state <= I2F_IDLE;
                        end
                        endcase
                end
        end

endmodule

//--- logic/float_to_int.sv
/* Single-precision float to signed integer, truncating toward zero.
   Subnormals give 0. NaN, infinities and overflow saturate and raise invalid,
   with every NaN going to the negative word */
`timescale 1ns/10ps
`include "fcvt_macros.svh"

module float_to_int (
        input  logic            clk,
        input  logic            rst,
        input  logic            start,
        input  fcvt_pkg::word_t a,
        output fcvt_pkg::word_t z,
        output logic            invalid,
        output logic            done
);
        import fcvt_pkg::*;

        f2i_state_t state;

        word_t      a_q;
        logic       a_sign;
        exp_t       a_exp;
        man_t       a_man;
        logic       a_frac_zero;
        exp_t       shift_full;

        word_t      mag;
        logic       neg;
        logic       inv_q;
        logic [4:0] shift_cnt;

        assign a_sign      = a_q[`FCVT_WORD_BITS-1];
        assign a_exp       = a_q[`FCVT_WORD_BITS-2:`FCVT_MAN_BITS];
        assign a_man       = {1'b1, a_q[`FCVT_MAN_BITS-1:0]};
        assign a_frac_zero = (a_q[`FCVT_MAN_BITS-1:0] == '0);

        // Mantissa sits at the top of the word, so the right shift is 31 minus the exponent
        assign shift_full = exp_t'(`FCVT_EXP_BIAS + `FCVT_WORD_BITS - 1) - a_exp;

        always_ff @(posedge clk) begin
                if (!rst) begin
                        state <= F2I_IDLE;
                        done  <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                        F2I_IDLE: begin
                                if (start) begin
                                        a_q   <= a;
                                        state <= F2I_DECODE;
                                end
                        end

                        F2I_DECODE: begin
                                neg   <= 1'b0;
                                inv_q <= 1'b0;
                                state <= F2I_RESULT;
                                if (a_exp == '1) begin
                                        inv_q <= 1'b1;
                                        mag   <= (a_sign || !a_frac_zero) ?
                                                 `FCVT_INT_MIN : `FCVT_INT_MAX;
                                end else if (a_exp < exp_t'(`FCVT_EXP_BIAS)) begin
                                        // Magnitude below one, subnormals included
                                        mag <= '0;
                                end else if (a_exp >= exp_t'(`FCVT_EXP_BIAS + 31)) begin
                                        if (a_sign && a_frac_zero &&
                                            a_exp == exp_t'(`FCVT_EXP_BIAS + 31)) begin
                                                mag <= `FCVT_INT_MIN;
                                        end else begin
                                                inv_q <= 1'b1;
                                                mag   <= a_sign ? `FCVT_INT_MIN : `FCVT_INT_MAX;
                                        end
                                end else begin
                                        mag       <= {a_man, 8'b0};
                                        neg       <= a_sign;
                                        shift_cnt <= shift_full[4:0];
                                        state     <= F2I_SHIFT;
                                end
                        end

                        F2I_SHIFT: begin
                                // Up to four bits per step, the bits shifted out are dropped
                                if (shift_cnt > 5'd4) begin
                                        mag       <= mag >> 4;
                                        shift_cnt <= shift_cnt - 5'd4;
                                end else begin
                                        mag   <= mag >> shift_cnt;
                                        state <= F2I_RESULT;
                                end
                        end

                        F2I_RESULT: begin
                                z       <= neg ? -mag : mag;
                                invalid <= inv_q;
                                done    <= 1'b1;
                                state   <= F2I_IDLE;
                        end

                        default: begin
                                state <= F2I_IDLE;
                        end
                        endcase
                end
        end

endmodule

//--- logic/fcvt_ctrl.sv
/* Four-phase req/ack responder. A new req is taken only after ack has dropped,
   and result and invalid hold steady while ack is high */
`timescale 1ns/10ps
`include "fcvt_macros.svh"

module fcvt_ctrl (
        input  logic            clk,
        input  logic            rst,
        input  logic            req,
        input  fcvt_pkg::op_t   op,
        input  fcvt_pkg::word_t operand,
        output logic            ack,
        output fcvt_pkg::word_t result,
        output logic            invalid,
        output fcvt_pkg::word_t conv_operand,
        output logic            i2f_start,
        input  logic            i2f_done,
        input  fcvt_pkg::word_t i2f_z,
        output logic            f2i_start,
        input  logic            f2i_done,
        input  fcvt_pkg::word_t f2i_z,
        input  logic            f2i_invalid
);
        import fcvt_pkg::*;

        ctrl_state_t state;
        op_t         op_q;

        always_ff @(posedge clk) begin
                if (!rst) begin
                        state     <= CTRL_IDLE;
                        ack       <= 1'b0;
                        result    <= '0;
                        invalid   <= 1'b0;
                        i2f_start <= 1'b0;
                        f2i_start <= 1'b0;
                end else begin
                        i2f_start <= 1'b0;
                        f2i_start <= 1'b0;
                        case (state)
                        CTRL_IDLE: begin
                                if (req) begin
                                        op_q         <= op;
                                        conv_operand <= operand;
                                        i2f_start    <= (op == op_t'(`FCVT_OP_I2F));
                                        f2i_start    <= (op == op_t'(`FCVT_OP_F2I));
                                        state        <= CTRL_RUN;
                                end
                        end

                        CTRL_RUN: begin
                                if (op_q == op_t'(`FCVT_OP_I2F) && i2f_done) begin
                                        result  <= i2f_z;
                                        invalid <= 1'b0;
                                        ack     <= 1'b1;
                                        state   <= CTRL_HOLD;
                                end else if (op_q == op_t'(`FCVT_OP_F2I) && f2i_done) begin
                                        result  <= f2i_z;
                                        invalid <= f2i_invalid;
                                        ack     <= 1'b1;
                                        state   <= CTRL_HOLD;
                                end
                        end

                        // Stays here for as long as the requester keeps req high
                        CTRL_HOLD: begin
                                if (!req) begin
                                        ack   <= 1'b0;
                                        state <= CTRL_RELEASE;
                                end
                        end

                        CTRL_RELEASE: begin
                                state <= CTRL_IDLE;
                        end

                        default: begin
                                state <= CTRL_IDLE;
                        end
                        endcase
                end
        end

endmodule

//--- logic/fcvt_top.sv
/* Integer/float conversion unit behind a four-phase req/ack handshake.
   op selects the direction, one request at a time */
`timescale 1ns/10ps
`include "fcvt_macros.svh"

module fcvt_top (
        input  logic            clk,
        input  logic            rst,
        input  logic            req,
        input  fcvt_pkg::op_t   op,
        input  fcvt_pkg::word_t operand,
        output logic            ack,
        output fcvt_pkg::word_t result,
        output logic            invalid
);
        import fcvt_pkg::*;

        word_t conv_operand;
        logic  i2f_start;
        logic  i2f_done;
        word_t i2f_z;
        logic  f2i_start;
        logic  f2i_done;
        word_t f2i_z;
        logic  f2i_invalid;

        fcvt_ctrl u_ctrl (
                .clk          (clk),
                .rst          (rst),
                .req          (req),
                .op           (op),
                .operand      (operand),
                .ack          (ack),
                .result       (result),
                .invalid      (invalid),
                .conv_operand (conv_operand),
                .i2f_start    (i2f_start),
                .i2f_done     (i2f_done),
                .i2f_z        (i2f_z),
                .f2i_start    (f2i_start),
                .f2i_done     (f2i_done),
                .f2i_z        (f2i_z),
                .f2i_invalid  (f2i_invalid)
        );

        // Both converters see the same captured operand, only one is started
        int_to_float u_i2f (
                .clk   (clk),
                .rst   (rst),
                .start (i2f_start),
                .a     (conv_operand),
                .z     (i2f_z),
                .done  (i2f_done)
        );

        float_to_int u_f2i (
                .clk     (clk),
                .rst     (rst),
                .start   (f2i_start),
                .a       (conv_operand),
                .z       (f2i_z),
                .invalid (f2i_invalid),
                .done    (f2i_done)
        );

endmodule

//--- sim/fcvt_tb.sv
/* Directed testbench for the conversion unit. Expected values come from local
   reference functions, and random operands use $urandom seeded once with 30 */
`timescale 1ns/10ps
`include "fcvt_macros.svh"

module fcvt_tb;
        import fcvt_pkg::*;

        logic  clk;
        logic  rst;
        logic  req;
        op_t   op;
        word_t operand;
        logic  ack;
        word_t result;
        logic  invalid;
        word_t seed_val;

        fcvt_top u_dut (
                .clk     (clk),
                .rst     (rst),
                .req     (req),
                .op      (op),
                .operand (operand),
                .ack     (ack),
                .result  (result),
                .invalid (invalid)
        );

        always begin
                #50 clk = ~clk;
        end

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        task automatic check_word(input string name, input word_t expected, input word_t actual);
                if (actual !== expected) begin
                        report_failure($sformatf("FAILED %s: expected %h, actual %h",
                                                 name, expected, actual));
                end
        endtask

        task automatic check_flag(input string name, input bit expected, input bit actual);
                if (actual !== expected) begin
                        report_failure($sformatf("FAILED %s: expected %0b, actual %0b",
                                                 name, expected, actual));
                end
        endtask

        // Every call starts and ends 1 ns after a rising edge
        task automatic wait_ack(input logic level);
                int cycles;
                cycles = 0;
                while (ack !== level && cycles < 100) begin
                        @(posedge clk);
                        #1;
                        cycles++;
                end
                if (ack !== level) begin
                        if (level) begin
                                report_failure("ack never rose within 100 cycles of req rising");
                        end else begin
                                report_failure("ack never fell within 100 cycles of req falling");
                        end
                end
        endtask

        task automatic do_request(input op_t req_op, input word_t req_operand,
                                  output word_t res, output logic inv);
                op      = req_op;
                operand = req_operand;
                @(posedge clk);
                #1;
                req = 1'b1;
                wait_ack(1'b1);
                res = result;
                inv = invalid;
                req = 1'b0;
                wait_ack(1'b0);
        endtask

        // Round to nearest, ties to even, on the bits below the 24-bit mantissa
        function automatic word_t ref_i2f(input word_t a);
                logic        sign;
                logic [31:0] mag;
                logic [32:0] mant;
                logic [31:0] rem;
                logic [31:0] half;
                int          msb;
                int          sh;
                int          i;
                if (a == '0) begin
                        return '0;
                end
                sign = a[31];
                mag  = sign ? (~a + 32'd1) : a;
                msb  = 0;
                for (i = 0; i < 32; i++) begin
                        if (mag[i]) begin
                                msb = i;
                        end
                end
                if (msb <= 23) begin
                        mant = 33'(mag) << (23 - msb);
                end else begin
                        sh   = msb - 23;
                        mant = 33'(mag >> sh);
                        rem  = mag & ((32'd1 << sh) - 32'd1);
                        half = 32'd1 << (sh - 1);
                        if (rem > half || (rem == half && mant[0])) begin
                                mant = mant + 33'd1;
                        end
                        if (mant[24]) begin
                                mant = mant >> 1;
                                msb  = msb + 1;
                        end
                end
                return {sign, 8'(msb + `FCVT_EXP_BIAS), mant[22:0]};
        endfunction

        task automatic run_i2f(input string name, input word_t a, input word_t expected);
                word_t res;
                logic  inv;
                do_request(op_t'(`FCVT_OP_I2F), a, res, inv);
                check_word(name, expected, res);
                check_flag({name, "_invalid"}, 1'b0, inv);
        endtask

        task automatic run_f2i(input string name, input word_t a, input word_t expected,
                               input bit expected_inv);
                word_t res;
                logic  inv;
                do_request(op_t'(`FCVT_OP_F2I), a, res, inv);
                check_word(name, expected, res);
                check_flag({name, "_invalid"}, expected_inv, inv);
        endtask

        task automatic test_reset_state;
                int n;
                for (n = 0; n < 10; n++) begin
                        check_flag("reset_ack", 1'b0, ack);
                        @(posedge clk);
                        #1;
                end
        endtask

        task automatic test_i2f_exact;
                run_i2f("i2f_zero", 32'd0, 32'h00000000);
                run_i2f("i2f_one", 32'd1, 32'h3f800000);
                run_i2f("i2f_minus_one", 32'hffffffff, 32'hbf800000);
                run_i2f("i2f_2p24", 32'd16777216, 32'h4b800000);
                run_i2f("i2f_int_min", 32'h80000000, 32'hcf000000);
        endtask

        task automatic test_i2f_rounding;
                word_t value;
                int    n;
                run_i2f("i2f_tie_down", 32'd16777217, 32'h4b800000);
                run_i2f("i2f_tie_up", 32'd16777219, 32'h4b800002);
                run_i2f("i2f_int_max", 32'h7fffffff, 32'h4f000000);
                for (n = 0; n < 500; n++) begin
                        value = $urandom;
                        run_i2f($sformatf("i2f_random_%0d", n), value, ref_i2f(value));
                end
        endtask

        task automatic test_f2i_range;
                word_t r;
                word_t value;
                word_t fbits;
                word_t back;
                logic  inv;
                int    n;
                run_f2i("f2i_1p5", 32'h3fc00000, 32'd1, 1'b0);
                run_f2i("f2i_minus_2p75", 32'hc0300000, 32'hfffffffe, 1'b0);
                run_f2i("f2i_0p5", 32'h3f000000, 32'd0, 1'b0);
                run_f2i("f2i_subnormal", 32'h00000001, 32'd0, 1'b0);
                run_f2i("f2i_minus_2p31", 32'hcf000000, 32'h80000000, 1'b0);
                for (n = 0; n < 500; n++) begin
                        r     = $urandom;
                        value = r[31] ? (32'd0 - word_t'(r[23:0])) : word_t'(r[23:0]);
                        do_request(op_t'(`FCVT_OP_I2F), value, fbits, inv);
                        check_word($sformatf("roundtrip_i2f_%0d", n), ref_i2f(value), fbits);
                        do_request(op_t'(`FCVT_OP_F2I), fbits, back, inv);
                        check_word($sformatf("roundtrip_%0d", n), value, back);
                        check_flag($sformatf("roundtrip_invalid_%0d", n), 1'b0, inv);
                end
        endtask

        task automatic test_f2i_invalid;
                run_f2i("f2i_3e9", 32'h4f32d05e, 32'h7fffffff, 1'b1);
                run_f2i("f2i_pos_inf", 32'h7f800000, 32'h7fffffff, 1'b1);
                run_f2i("f2i_minus_3e9", 32'hcf32d05e, 32'h80000000, 1'b1);
                run_f2i("f2i_neg_inf", 32'hff800000, 32'h80000000, 1'b1);
                run_f2i("f2i_nan", 32'h7fc00000, 32'h80000000, 1'b1);
        endtask

        task automatic test_back_pressure;
                word_t held;
                word_t res;
                logic  inv;
                int    n;
                op      = op_t'(`FCVT_OP_I2F);
                operand = 32'd12345;
                @(posedge clk);
                #1;
                req = 1'b1;
                wait_ack(1'b1);
                held = result;
                check_word("bp_result", ref_i2f(32'd12345), held);
                // A changed operand must not start a new conversion while ack is high
                operand = 32'd999;
                for (n = 0; n < 20; n++) begin
                        @(posedge clk);
                        #1;
                        check_flag("bp_ack_held", 1'b1, ack);
                        check_word("bp_result_held", held, result);
                end
                req = 1'b0;
                wait_ack(1'b0);
                do_request(op_t'(`FCVT_OP_F2I), 32'hc0300000, res, inv);
                check_word("bp_next", 32'hfffffffe, res);
                check_flag("bp_next_invalid", 1'b0, inv);
        endtask

        initial begin
                clk      = 1'b0;
                rst      = 1'b0;
                req      = 1'b0;
                op       = op_t'(`FCVT_OP_I2F);
                operand  = '0;
                seed_val = $urandom(30);
                repeat (5) @(posedge clk);
                #1;
                rst = 1'b1;
                test_reset_state();
                test_i2f_exact();
                test_i2f_rounding();
                test_f2i_range();
                test_f2i_invalid();
                test_back_pressure();
                $display("TEST RESULT: PASS");
                $finish;
        end

endmodule

//--- flist.f
+incdir+logic
logic/fcvt_pkg.sv
logic/int_to_float.sv
logic/float_to_int.sv
logic/fcvt_ctrl.sv
logic/fcvt_top.sv
sim/fcvt_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# The run counts as passed only when the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fcvt_tb -f flist.f -o fcvt_sim \
        && ./obj_dir/fcvt_sim | grep -q "TEST RESULT: PASS" \
        && echo "Simulation passed" \
        || { echo "Simulation failed"; exit 1; }
